// File: src/ip_rx_settings.svh
// protocol numbers, header sizes and field widths for the ip receive demux
// included by the package and by any rtl that needs the constants
`ifndef IP_RX_SETTINGS_SVH
`define IP_RX_SETTINGS_SVH

// ip protocol number that selects the udp branch
`define IP_PROTO_UDP 8'd17

// udp header bytes on the wire: ports, length, checksum
`define UDP_HDR_BYTES 8

// field widths used by the package types
`define IP_ADDR_WIDTH 32
`define UDP_PORT_WIDTH 16
`define LEN_WIDTH 16
`define DATA_WIDTH 8

`endif

// File: src/ip_rx_pkg.sv
// shared header, stream and state types for the ip receive demux
// referenced by scoped name from the classifier, parser and top level
`include "ip_rx_settings.svh"

package ip_rx_pkg;

    // plain vectors with a meaning of their own
    typedef logic [`IP_ADDR_WIDTH-1:0]  ip_addr_t;
    typedef logic [`UDP_PORT_WIDTH-1:0] udp_port_t;
    typedef logic [`LEN_WIDTH-1:0]      len16_t;

    // ip header fields kept on the receive path, 104 bits
    typedef struct packed {
        logic [5:0] dscp;
        logic [1:0] ecn;
        len16_t     length;
        logic [7:0] ttl;
        logic [7:0] protocol;
        ip_addr_t   source_ip;
        ip_addr_t   dest_ip;
    } ip_hdr_t;

    // ip fields plus the parsed udp header
    typedef struct packed {
        ip_hdr_t   ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        len16_t    length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // one payload byte, user marks a bad frame
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic                   last;
        logic                   user;
    } stream_beat_t;

    typedef enum logic {cls_idle, cls_payload} classify_state_t;

    typedef enum logic [2:0] {
        prs_idle, prs_hdr_bytes, prs_hdr_out, prs_payload, prs_drain
    } parse_state_t;

endpackage

// File: src/ip_proto_classifier.sv
// steers each incoming ip frame to the udp parser or the raw ip output
// header and payload both pass through with zero latency
`timescale 1ns/1ps
`include "ip_rx_settings.svh"

module ip_proto_classifier (
    input  logic                   clk,
    input  logic                   rst,
    input  ip_rx_pkg::ip_hdr_t     in_hdr,
    input  logic                   in_hdr_valid,
    output logic                   in_hdr_ready,
    input  ip_rx_pkg::stream_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output ip_rx_pkg::ip_hdr_t     raw_hdr,
    output logic                   raw_hdr_valid,
    input  logic                   raw_hdr_ready,
    output ip_rx_pkg::stream_beat_t raw_beat,
    output logic                   raw_valid,
    input  logic                   raw_ready,
    output ip_rx_pkg::ip_hdr_t     udp_ip_hdr,
    output logic                   udp_ip_hdr_valid,
    input  logic                   udp_ip_hdr_ready,
    output ip_rx_pkg::stream_beat_t udp_beat,
    output logic                   udp_valid,
    input  logic                   udp_ready,
    output logic                   busy
);

    ip_rx_pkg::classify_state_t state_q;
    // route held for the payload of the current frame
    logic route_udp_q;
    logic hdr_is_udp;
    logic in_idle;
    logic hdr_xfer;
    logic last_xfer;

    assign hdr_is_udp = (in_hdr.protocol == `IP_PROTO_UDP);
    assign in_idle    = (state_q == ip_rx_pkg::cls_idle);
    assign hdr_xfer   = in_hdr_valid && in_hdr_ready;
    assign last_xfer  = in_valid && in_ready && in_beat.last;

    // both branches see the same header and bytes, only valid is steered
    assign raw_hdr    = in_hdr;
    assign udp_ip_hdr = in_hdr;
    assign raw_beat   = in_beat;
    assign udp_beat   = in_beat;

    // header phase uses the live protocol field
    assign raw_hdr_valid    = in_idle && in_hdr_valid && !hdr_is_udp;
    assign udp_ip_hdr_valid = in_idle && in_hdr_valid && hdr_is_udp;
    assign in_hdr_ready     = in_idle && (hdr_is_udp ? udp_ip_hdr_ready : raw_hdr_ready);

    // payload phase uses the latched route
    assign raw_valid = !in_idle && in_valid && !route_udp_q;
    assign udp_valid = !in_idle && in_valid && route_udp_q;
    assign in_ready  = !in_idle && (route_udp_q ? udp_ready : raw_ready);

    assign busy = !in_idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ip_rx_pkg::cls_idle;
            route_udp_q <= 1'b0;
        end else begin
            case (state_q)
                ip_rx_pkg::cls_idle: begin
                    if (hdr_xfer) begin
                        route_udp_q <= hdr_is_udp;
                        state_q     <= ip_rx_pkg::cls_payload;
                    end
                end
                default: begin
                    // back to idle once the final byte has gone out
                    if (last_xfer) begin
                        state_q <= ip_rx_pkg::cls_idle;
                    end
                end
            endcase
        end
    end

    // route stays put from header transfer to the last byte
    route_stable_a: assert property (@(posedge clk) disable iff (rst)
        (state_q == ip_rx_pkg::cls_payload) |=>
            (state_q != ip_rx_pkg::cls_payload) || $stable(route_udp_q));

    // no byte leaks out before its header has been routed
    no_payload_in_idle_a: assert property (@(posedge clk) disable iff (rst)
        in_idle |-> !(raw_valid || udp_valid));

endmodule

// File: src/udp_header_parser.sv
// takes an ip frame, strips the 8 byte udp header and emits it as fields
// payload is trimmed to the udp length, short frames raise error pulses
`timescale 1ns/1ps
`include "ip_rx_settings.svh"

module udp_header_parser (
    input  logic                    clk,
    input  logic                    rst,
    input  ip_rx_pkg::ip_hdr_t      ip_hdr,
    input  logic                    ip_hdr_valid,
    output logic                    ip_hdr_ready,
    input  ip_rx_pkg::stream_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output ip_rx_pkg::udp_hdr_t     udp_hdr,
    output logic                    udp_hdr_valid,
    input  logic                    udp_hdr_ready,
    output ip_rx_pkg::stream_beat_t out_beat,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    busy,
    output logic                    error_header_early_termination,
    output logic                    error_payload_early_termination
);

    ip_rx_pkg::parse_state_t state_q;
    ip_rx_pkg::ip_hdr_t      ip_hdr_q;
    // udp header bytes, first byte ends up in the top bits
    logic [`UDP_HDR_BYTES*8-1:0] hdr_sr;
    ip_rx_pkg::len16_t cnt_q;
    ip_rx_pkg::len16_t udp_len;
    ip_rx_pkg::len16_t pay_len;
    logic at_end;
    logic beat_xfer;
    logic err_hdr_q;
    logic err_pay_q;

    assign udp_len   = hdr_sr[31:16];
    assign pay_len   = udp_len - ip_rx_pkg::len16_t'(`UDP_HDR_BYTES);
    // current beat is the final udp payload byte
    assign at_end    = (cnt_q + 16'd1 == pay_len);
    assign beat_xfer = in_valid && in_ready;

    // fields big-endian as they arrived
    always_comb begin
        udp_hdr.ip          = ip_hdr_q;
        udp_hdr.source_port = hdr_sr[63:48];
        udp_hdr.dest_port   = hdr_sr[47:32];
        udp_hdr.length      = udp_len;
        udp_hdr.checksum    = hdr_sr[15:0];
    end

    assign ip_hdr_ready  = (state_q == ip_rx_pkg::prs_idle);
    assign udp_hdr_valid = (state_q == ip_rx_pkg::prs_hdr_out);
    assign out_valid     = (state_q == ip_rx_pkg::prs_payload) && in_valid;

    // header bytes and extra bytes are swallowed, payload follows out_ready
    always_comb begin
        case (state_q)
            ip_rx_pkg::prs_hdr_bytes: in_ready = 1'b1;
            ip_rx_pkg::prs_drain:     in_ready = 1'b1;
            ip_rx_pkg::prs_payload:   in_ready = out_ready;
            default:                  in_ready = 1'b0;
        endcase
    end

    // last placed at the udp length, user flags a frame cut short
    always_comb begin
        out_beat.data = in_beat.data;
        out_beat.last = in_beat.last || at_end;
        out_beat.user = in_beat.user || (in_beat.last && !at_end);
    end

    assign busy = (state_q != ip_rx_pkg::prs_idle);
    assign error_header_early_termination  = err_hdr_q;
    assign error_payload_early_termination = err_pay_q;

    // capture path
    always_ff @(posedge clk) begin
        if (ip_hdr_valid && ip_hdr_ready) begin
            ip_hdr_q <= ip_hdr;
        end
        if (state_q == ip_rx_pkg::prs_hdr_bytes && beat_xfer) begin
            hdr_sr <= {hdr_sr[`UDP_HDR_BYTES*8-9:0], in_beat.data};
        end
    end

    always_ff @(posedge clk) begin
        // error strobes last one cycle
        err_hdr_q <= 1'b0;
        err_pay_q <= 1'b0;
        if (rst) begin
            state_q <= ip_rx_pkg::prs_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ip_rx_pkg::prs_idle: begin
                    cnt_q <= '0;
                    if (ip_hdr_valid) begin
                        state_q <= ip_rx_pkg::prs_hdr_bytes;
                    end
                end
                ip_rx_pkg::prs_hdr_bytes: begin
                    if (beat_xfer) begin
                        cnt_q <= cnt_q + 16'd1;
                        if (in_beat.last) begin
                            err_hdr_q <= 1'b1;
                            state_q   <= ip_rx_pkg::prs_idle;
                        end else if (cnt_q == ip_rx_pkg::len16_t'(`UDP_HDR_BYTES - 1)) begin
                            state_q <= ip_rx_pkg::prs_hdr_out;
                        end
                    end
                end
                ip_rx_pkg::prs_hdr_out: begin
                    cnt_q <= '0;
                    if (udp_hdr_ready) begin
                        // empty udp payload goes straight to drain
                        if (udp_len <= ip_rx_pkg::len16_t'(`UDP_HDR_BYTES)) begin
                            state_q <= ip_rx_pkg::prs_drain;
                        end else begin
                            state_q <= ip_rx_pkg::prs_payload;
                        end
                    end
                end
                ip_rx_pkg::prs_payload: begin
                    if (beat_xfer) begin
                        cnt_q <= cnt_q + 16'd1;
                        if (at_end) begin
                            state_q <= in_beat.last ? ip_rx_pkg::prs_idle : ip_rx_pkg::prs_drain;
                        end else if (in_beat.last) begin
                            err_pay_q <= 1'b1;
                            state_q   <= ip_rx_pkg::prs_idle;
                        end
                    end
                end
                default: begin
                    if (beat_xfer && in_beat.last) begin
                        state_q <= ip_rx_pkg::prs_idle;
                    end
                end
            endcase
        end
    end

    // header strictly precedes payload on the udp output
    hdr_before_payload_a: assert property (@(posedge clk) disable iff (rst)
        !(udp_hdr_valid && out_valid));

endmodule

// File: src/ip_rx_demux_top.sv
// receive-side ip demux: udp frames to the header parser, others to raw ip
// classifier and parser run side by side on different frames
`timescale 1ns/1ps

module ip_rx_demux_top (
    input  logic                    clk,
    input  logic                    rst,
    // ip frame input
    input  ip_rx_pkg::ip_hdr_t      ip_hdr,
    input  logic                    ip_hdr_valid,
    output logic                    ip_hdr_ready,
    input  ip_rx_pkg::stream_beat_t ip_beat,
    input  logic                    ip_valid,
    output logic                    ip_ready,
    // non-udp frames, unchanged
    output ip_rx_pkg::ip_hdr_t      raw_hdr,
    output logic                    raw_hdr_valid,
    input  logic                    raw_hdr_ready,
    output ip_rx_pkg::stream_beat_t raw_beat,
    output logic                    raw_valid,
    input  logic                    raw_ready,
    // parsed udp frames
    output ip_rx_pkg::udp_hdr_t     udp_hdr,
    output logic                    udp_hdr_valid,
    input  logic                    udp_hdr_ready,
    output ip_rx_pkg::stream_beat_t udp_beat,
    output logic                    udp_valid,
    input  logic                    udp_ready,
    // status
    output logic                    rx_busy,
    output logic                    error_header_early_termination,
    output logic                    error_payload_early_termination
);

    // classifier to parser
    ip_rx_pkg::ip_hdr_t      cls_udp_hdr;
    logic                    cls_udp_hdr_valid;
    logic                    cls_udp_hdr_ready;
    ip_rx_pkg::stream_beat_t cls_udp_beat;
    logic                    cls_udp_valid;
    logic                    cls_udp_ready;
    logic                    cls_busy;
    logic                    prs_busy;

    ip_proto_classifier ip_proto_classifier_inst (
        .clk(clk), .rst(rst),
        .in_hdr(ip_hdr), .in_hdr_valid(ip_hdr_valid), .in_hdr_ready(ip_hdr_ready),
        .in_beat(ip_beat), .in_valid(ip_valid), .in_ready(ip_ready),
        .raw_hdr(raw_hdr), .raw_hdr_valid(raw_hdr_valid), .raw_hdr_ready(raw_hdr_ready),
        .raw_beat(raw_beat), .raw_valid(raw_valid), .raw_ready(raw_ready),
        .udp_ip_hdr(cls_udp_hdr), .udp_ip_hdr_valid(cls_udp_hdr_valid),
        .udp_ip_hdr_ready(cls_udp_hdr_ready),
        .udp_beat(cls_udp_beat), .udp_valid(cls_udp_valid), .udp_ready(cls_udp_ready),
        .busy(cls_busy)
    );

    udp_header_parser udp_header_parser_inst (
        .clk(clk), .rst(rst),
        .ip_hdr(cls_udp_hdr), .ip_hdr_valid(cls_udp_hdr_valid),
        .ip_hdr_ready(cls_udp_hdr_ready),
        .in_beat(cls_udp_beat), .in_valid(cls_udp_valid), .in_ready(cls_udp_ready),
        .udp_hdr(udp_hdr), .udp_hdr_valid(udp_hdr_valid), .udp_hdr_ready(udp_hdr_ready),
        .out_beat(udp_beat), .out_valid(udp_valid), .out_ready(udp_ready),
        .busy(prs_busy),
        .error_header_early_termination(error_header_early_termination),
        .error_payload_early_termination(error_payload_early_termination)
    );

    assign rx_busy = cls_busy | prs_busy;

endmodule

// File: tb/tb_ip_rx_demux.sv
// replays frames from the vectors file through the ip receive demux
// and checks both output branches against queues of expected traffic
`timescale 1ns/1ps
`include "ip_rx_settings.svh"

module tb_ip_rx_demux;

    localparam int MAX_VEC = 32;
    localparam int MAX_LEN = 64;
    localparam int WAIT_LIMIT = 400;

    logic clk;
    logic rst;
    ip_rx_pkg::ip_hdr_t      ip_hdr;
    logic                    ip_hdr_valid, ip_hdr_ready;
    ip_rx_pkg::stream_beat_t ip_beat;
    logic                    ip_valid, ip_ready;
    ip_rx_pkg::ip_hdr_t      raw_hdr;
    logic                    raw_hdr_valid, raw_hdr_ready;
    ip_rx_pkg::stream_beat_t raw_beat;
    logic                    raw_valid, raw_ready;
    ip_rx_pkg::udp_hdr_t     udp_hdr;
    logic                    udp_hdr_valid, udp_hdr_ready;
    ip_rx_pkg::stream_beat_t udp_beat;
    logic                    udp_valid, udp_ready;
    logic                    rx_busy;
    logic                    error_header_early_termination;
    logic                    error_payload_early_termination;

    // one entry per frame line
    int          v_proto [MAX_VEC];
    logic [31:0] v_src [MAX_VEC];
    logic [31:0] v_dst [MAX_VEC];
    int          v_dscp [MAX_VEC];
    int          v_ttl [MAX_VEC];
    int          v_len [MAX_VEC];
    int          v_udp_len [MAX_VEC];
    int          v_code [MAX_VEC];
    int          num_vec;
    // expected transfers per channel
    // 0 raw header, 1 raw bytes, 2 udp header, 3 udp bytes
    logic [191:0] exp_q [4][$];
    int exp_hdr_err, exp_pay_err, hdr_err_seen, pay_err_seen;
    int fail_count, check_count, tests_run;
    logic aborted = 1'b0;
    logic stall_en = 1'b0;
    logic [31:0] data_lcg = 32'h1fe7;
    logic [31:0] stall_lcg = 32'h1fe7;

    ip_rx_demux_top ip_rx_demux_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic expect_equal(input logic [191:0] got, input logic [191:0] want,
                                input string what);
        check_count++;
        if (got !== want) begin
            fail_count++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // marks the run as broken so no more frames are driven
    task automatic record_abort(input string why);
        fail_count++;
        aborted = 1'b1;
        $display("run aborted at %0t: %s", $time, why);
    endtask

    // an output transfer must match the oldest expected entry of its channel
    task automatic take_output(input int ch, input logic [191:0] got, input string what);
        if (exp_q[ch].size() == 0) begin
            fail_count++;
            $display("unexpected transfer on the %s output at %0t", what, $time);
        end else begin
            expect_equal(got, exp_q[ch].pop_front(), what);
        end
    endtask

    task automatic load_vectors();
        int fd;
        int got;
        string line;
        fd = $fopen("tb/ip_rx_vectors.txt", "r");
        if (fd == 0) begin
            record_abort("could not open tb/ip_rx_vectors.txt");
            return;
        end
        num_vec = 0;
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            got = $fgets(line, fd);
            // hash lines describe the columns
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%d %h %h %d %d %d %d %d", v_proto[num_vec],
                    v_src[num_vec], v_dst[num_vec], v_dscp[num_vec], v_ttl[num_vec],
                    v_len[num_vec], v_udp_len[num_vec], v_code[num_vec]);
                if (got == 8)
                    num_vec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_frame(input int idx);
        ip_rx_pkg::ip_hdr_t      h;
        ip_rx_pkg::udp_hdr_t     uh;
        ip_rx_pkg::stream_beat_t b;
        logic [7:0] bytes [MAX_LEN];
        int n;
        int outcome;
        int pay_out;
        int waited;
        n = v_len[idx];
        h.dscp = 6'(v_dscp[idx]);
        h.ecn = 2'(idx);
        h.length = 16'(n + 20);
        h.ttl = 8'(v_ttl[idx]);
        h.protocol = 8'(v_proto[idx]);
        h.source_ip = v_src[idx];
        h.dest_ip = v_dst[idx];
        for (int i = 0; i < MAX_LEN; i++) begin
            data_lcg = lcg_step(data_lcg);
            bytes[i] = data_lcg[23:16];
        end
        // outcome from protocol and the two lengths
        if (h.protocol != `IP_PROTO_UDP)
            outcome = 0;
        else if (n <= `UDP_HDR_BYTES)
            outcome = 2;
        else if (n < v_udp_len[idx])
            outcome = 3;
        else
            outcome = 1;
        expect_equal(192'(outcome), 192'(v_code[idx]), "outcome code in vector line");
        if (outcome == 0) begin
            exp_q[0].push_back(192'(h));
            for (int i = 0; i < n; i++) begin
                b.data = bytes[i];
                b.last = (i == n - 1);
                b.user = 1'b0;
                exp_q[1].push_back(192'(b));
            end
        end else begin
            // udp length lives in header bytes 5 and 6
            bytes[4] = 8'(v_udp_len[idx] >> 8);
            bytes[5] = 8'(v_udp_len[idx]);
            uh.ip = h;
            uh.source_port = {bytes[0], bytes[1]};
            uh.dest_port = {bytes[2], bytes[3]};
            uh.length = {bytes[4], bytes[5]};
            uh.checksum = {bytes[6], bytes[7]};
            pay_out = (outcome == 1) ? v_udp_len[idx] - `UDP_HDR_BYTES : n - `UDP_HDR_BYTES;
            if (outcome == 2)
                exp_hdr_err++;
            else
                exp_q[2].push_back(192'(uh));
            if (outcome == 3)
                exp_pay_err++;
            for (int i = 0; i < pay_out && outcome != 2; i++) begin
                b.data = bytes[`UDP_HDR_BYTES + i];
                b.last = (i == pay_out - 1);
                b.user = (outcome == 3) && (i == pay_out - 1);
                exp_q[3].push_back(192'(b));
            end
        end
        ip_hdr <= h;
        ip_hdr_valid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!ip_hdr_ready && waited < WAIT_LIMIT);
        if (!ip_hdr_ready) begin
            record_abort("ip header was not accepted before the timeout");
            return;
        end
        ip_hdr_valid <= 1'b0;
        for (int i = 0; i < n; i++) begin
            b.data = bytes[i];
            b.last = (i == n - 1);
            b.user = 1'b0;
            ip_beat <= b;
            ip_valid <= 1'b1;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!ip_ready && waited < WAIT_LIMIT);
            if (!ip_ready) begin
                record_abort("payload byte was not accepted before the timeout");
                return;
            end
        end
        ip_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0
                || rx_busy) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            record_abort("outputs did not drain before the timeout");
            return;
        end
        // error strobes trail the final byte by one cycle
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int fails_before);
        tests_run++;
        if (fail_count == fails_before)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: %0d failed checks", tests_run, name, fail_count - fails_before);
    endtask

    task automatic run_frames(input string name, input logic stalls);
        int fails_before;
        fails_before = fail_count;
        stall_en = stalls;
        for (int i = 0; i < num_vec && !aborted; i++)
            drive_frame(i);
        wait_drained();
        expect_equal(192'(hdr_err_seen), 192'(exp_hdr_err), "header early termination pulses");
        expect_equal(192'(pay_err_seen), 192'(exp_pay_err), "payload early termination pulses");
        finish_test(name, fails_before);
    endtask

    // random back-pressure with about one stall in four per channel
    initial begin : stall_gen
        raw_hdr_ready <= 1'b1;
        raw_ready <= 1'b1;
        udp_hdr_ready <= 1'b1;
        udp_ready <= 1'b1;
        forever begin
            @(posedge clk);
            stall_lcg = lcg_step(stall_lcg);
            raw_hdr_ready <= !stall_en || (stall_lcg[17:16] != 2'b00);
            raw_ready <= !stall_en || (stall_lcg[19:18] != 2'b00);
            udp_hdr_ready <= !stall_en || (stall_lcg[21:20] != 2'b00);
            udp_ready <= !stall_en || (stall_lcg[23:22] != 2'b00);
        end
    end

    // output monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (raw_hdr_valid && raw_hdr_ready)
                take_output(0, 192'(raw_hdr), "raw header");
            if (raw_valid && raw_ready)
                take_output(1, 192'(raw_beat), "raw byte");
            if (udp_hdr_valid && udp_hdr_ready)
                take_output(2, 192'(udp_hdr), "udp header");
            if (udp_valid && udp_ready)
                take_output(3, 192'(udp_beat), "udp byte");
            // a frame in flight keeps the busy flag up
            if (raw_valid || udp_valid)
                expect_equal(192'(rx_busy), 192'(1), "rx_busy during a frame");
            if (error_header_early_termination)
                hdr_err_seen++;
            if (error_payload_early_termination)
                pay_err_seen++;
        end
    end

    initial begin : main_seq
        int idle_fails;
        rst <= 1'b1;
        ip_hdr <= '0;
        ip_hdr_valid <= 1'b0;
        ip_beat <= '0;
        ip_valid <= 1'b0;
        load_vectors();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // no input offered and nothing may come out
        idle_fails = fail_count;
        repeat (20) begin
            @(posedge clk);
            expect_equal(192'({raw_hdr_valid, raw_valid, udp_hdr_valid, udp_valid, rx_busy,
                error_header_early_termination, error_payload_early_termination}),
                192'(0), "outputs idle after reset");
        end
        finish_test("idle after reset", idle_fails);
        run_frames("frames with ready held high", 1'b0);
        run_frames("frames with random ready stalls", 1'b1);
        $display("tests %0d, checks %0d, failed checks %0d", tests_run, check_count, fail_count);
        if (fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: ip_rx_demux_top.f
+incdir+src
src/ip_rx_pkg.sv
src/ip_proto_classifier.sv
src/udp_header_parser.sv
src/ip_rx_demux_top.sv
tb/tb_ip_rx_demux.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the ip receive demux testbench with verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ip_rx_demux \
    -f ip_rx_demux_top.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: tb/ip_rx_vectors.txt
# columns are proto src_ip dst_ip dscp ttl pay_len udp_len outcome
# outcome codes 0 raw, 1 udp, 2 short udp header, 3 short udp payload
6  c0a80001 c0a80002 0  64  12 0  0
17 c0a80003 0a000001 10 32  20 20 1
1  0a000002 0a000003 46 255 1  0  0
17 0a000004 c0a80004 0  128 30 16 1
17 ac100001 ac100002 8  1   5  20 2
6  ac100003 ac100004 12 60  40 0  0
17 c0a80005 c0a80006 0  64  14 24 3
58 fe800001 fe800002 63 2   7  0  0
17 01020304 05060708 4  99  9  9  1
17 0a0a0a0a 0b0b0b0b 20 10  8  40 2
6  c0a80007 c0a80008 0  64  64 0  0
17 c0a80009 c0a8000a 34 200 64 50 1
17 7f000001 7f000002 0  64  3  12 2
2  e0000001 c0a8000b 1  1   2  0  0
17 c0a8000c c0a8000d 0  64  33 60 3
17 c0a8000e c0a8000f 16 64  17 17 1
6  0a000010 0a000011 0  64  25 0  0
17 0a000012 0a000013 0  64  1  9  2
